// File: rtl/ntm_math_pkg.sv
`default_nettype none

package ntm_math_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Default widths
  ////////////////////////////////////////////////////////////////////////////

  // Operand, modulus and result width
  localparam int DEFAULT_DATA_SIZE = 64;

  // Element index and vector length width
  localparam int DEFAULT_CONTROL_SIZE = 64;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer state
  ////////////////////////////////////////////////////////////////////////////

  // Shared by the reducer and the scalar multiplier loops
  typedef enum logic [1:0] {
    // Waiting for start
    seq_idle = 2'd0,
    // One loop step per cycle
    seq_run  = 2'd1,
    // Result valid, ready high for this cycle only
    seq_done = 2'd2
  } ntm_seq_state_t;

endpackage

`default_nettype wire

// File: rtl/ntm_scalar_modular_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

// data_out = data_a_in * data_b_in mod modulo_in
module ntm_scalar_modular_multiplier
  import ntm_math_pkg::*;
#(
  parameter int DATA_SIZE    = DEFAULT_DATA_SIZE,
  parameter int CONTROL_SIZE = DEFAULT_CONTROL_SIZE
) (
  input  wire                  CLK,
  input  wire                  RST,

  // Handshake
  input  wire                  start,
  output logic                 ready,

  // Operands, held stable from start to ready
  input  wire  [DATA_SIZE-1:0] modulo_in,
  input  wire  [DATA_SIZE-1:0] data_a_in,
  input  wire  [DATA_SIZE-1:0] data_b_in,
  output logic [DATA_SIZE-1:0] data_out
);

  ////////////////////////////////////////////////////////////////////////////
  // Constants and signals
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [CONTROL_SIZE-1:0] LAST_STEP = CONTROL_SIZE'(DATA_SIZE - 1);

  ntm_seq_state_t state;

  // Low while waiting on the reducer, high during the B scan
  logic iterating;
  logic [CONTROL_SIZE-1:0] step_count;

  // Reducer handshake
  logic reduce_start;
  logic reduce_ready;
  logic [DATA_SIZE-1:0] reduced_a;

  // Accumulator stays below the modulus
  logic [DATA_SIZE-1:0] accumulator;
  logic [DATA_SIZE-1:0] multiplier_shift;

  // Extra top bit keeps 2 * acc and acc + a exact for any modulus
  logic [DATA_SIZE:0] doubled;
  logic [DATA_SIZE-1:0] doubled_mod;
  logic [DATA_SIZE:0] addend_sum;
  logic [DATA_SIZE-1:0] addend_mod;
  logic [DATA_SIZE-1:0] accumulator_next;

  // Value below 2 * modulus brought below modulus
  function automatic logic [DATA_SIZE-1:0] reduce_once(input logic [DATA_SIZE:0] value,
                                                        input logic [DATA_SIZE-1:0] modulus);
    logic [DATA_SIZE:0] difference;
    difference = value - {1'b0, modulus};
    return difference[DATA_SIZE] ? value[DATA_SIZE-1:0] : difference[DATA_SIZE-1:0];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Operand A reduction
  ////////////////////////////////////////////////////////////////////////////

  ntm_scalar_modular_reducer #(
    .DATA_SIZE(DATA_SIZE)
  ) u_reducer (
    .CLK      (CLK),
    .RST      (RST),
    .start    (reduce_start),
    .ready    (reduce_ready),
    .modulo_in(modulo_in),
    .data_in  (data_a_in),
    .data_out (reduced_a)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Interleaved step
  ////////////////////////////////////////////////////////////////////////////

  // acc = 2 * acc mod m, then + a mod m when the B bit is set
  assign doubled     = {accumulator, 1'b0};
  assign doubled_mod = reduce_once(doubled, modulo_in);
  assign addend_sum  = {1'b0, doubled_mod} + {1'b0, reduced_a};
  assign addend_mod  = reduce_once(addend_sum, modulo_in);

  assign accumulator_next = multiplier_shift[DATA_SIZE-1] ? addend_mod : doubled_mod;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= seq_idle;
      iterating    <= 1'b0;
      step_count   <= '0;
      reduce_start <= 1'b0;
    end else begin
      // Reducer start is a single-cycle pulse
      reduce_start <= 1'b0;
      case (state)
        seq_idle: begin
          if (start) begin
            // Launch cycle
            state        <= seq_run;
            iterating    <= 1'b0;
            reduce_start <= 1'b1;
          end
        end
        seq_run: begin
          if (!iterating) begin
            if (reduce_ready) begin
              iterating  <= 1'b1;
              step_count <= '0;
            end
          end else begin
            step_count <= step_count + 1'b1;
            // LSB of B handled this cycle
            if (step_count == LAST_STEP) begin
              state     <= seq_done;
              iterating <= 1'b0;
            end
          end
        end
        seq_done: begin
          state <= seq_idle;
        end
        default: begin
          state <= seq_idle;
        end
      endcase
    end
  end

  // Datapath, B scanned from its MSB
  always_ff @(posedge CLK) begin
    if (state == seq_run && !iterating && reduce_ready) begin
      accumulator      <= '0;
      multiplier_shift <= data_b_in;
    end else if (state == seq_run && iterating) begin
      accumulator      <= accumulator_next;
      multiplier_shift <= multiplier_shift << 1;
    end
  end

  assign ready    = (state == seq_done);
  assign data_out = accumulator;

endmodule

`default_nettype wire

// File: rtl/ntm_scalar_modular_reducer.sv
`timescale 1ns/1ps
`default_nettype none

// data_out = data_in mod modulo_in, one dividend bit per cycle
module ntm_scalar_modular_reducer
  import ntm_math_pkg::*;
#(
  parameter int DATA_SIZE = DEFAULT_DATA_SIZE
) (
  input  wire                  CLK,
  input  wire                  RST,

  // Handshake
  input  wire                  start,
  output logic                 ready,

  // Operands, held stable from start to ready
  input  wire  [DATA_SIZE-1:0] modulo_in,
  input  wire  [DATA_SIZE-1:0] data_in,
  output logic [DATA_SIZE-1:0] data_out
);

  ////////////////////////////////////////////////////////////////////////////
  // Constants and signals
  ////////////////////////////////////////////////////////////////////////////

  // Enough bits to count DATA_SIZE steps
  localparam int COUNT_SIZE = $clog2(DATA_SIZE);
  localparam logic [COUNT_SIZE-1:0] LAST_STEP = COUNT_SIZE'(DATA_SIZE - 1);

  ntm_seq_state_t state;
  logic [COUNT_SIZE-1:0] step_count;

  // Dividend bits still to be shifted in, MSB first
  logic [DATA_SIZE-1:0] dividend_shift;

  // Running remainder, always below the modulus
  logic [DATA_SIZE-1:0] remainder;

  // One bit wider so remainder * 2 + 1 never overflows
  logic [DATA_SIZE:0] shifted_remainder;
  logic [DATA_SIZE:0] trial_difference;
  logic [DATA_SIZE-1:0] remainder_next;

  ////////////////////////////////////////////////////////////////////////////
  // Restoring step
  ////////////////////////////////////////////////////////////////////////////

  assign shifted_remainder = {remainder, dividend_shift[DATA_SIZE-1]};
  assign trial_difference  = shifted_remainder - {1'b0, modulo_in};

  // Borrow in the top bit means remainder below modulus, keep it
  assign remainder_next = trial_difference[DATA_SIZE] ? shifted_remainder[DATA_SIZE-1:0]
                                                      : trial_difference[DATA_SIZE-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  // idle -> run for DATA_SIZE cycles -> done for one cycle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= seq_idle;
      step_count <= '0;
    end else begin
      case (state)
        seq_idle: begin
          if (start) begin
            state      <= seq_run;
            step_count <= '0;
          end
        end
        seq_run: begin
          step_count <= step_count + 1'b1;
          // Last dividend bit consumed this cycle
          if (step_count == LAST_STEP) begin
            state <= seq_done;
          end
        end
        seq_done: begin
          state <= seq_idle;
        end
        default: begin
          state <= seq_idle;
        end
      endcase
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    if (state == seq_idle && start) begin
      dividend_shift <= data_in;
      remainder      <= '0;
    end else if (state == seq_run) begin
      dividend_shift <= dividend_shift << 1;
      remainder      <= remainder_next;
    end
  end

  // Remainder holds until the next start
  assign ready    = (state == seq_done);
  assign data_out = remainder;

endmodule

`default_nettype wire

// File: rtl/ntm_vector_modular_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

// data_out[i] = data_a_in[i] * data_b_in[i] mod modulo_in, one element at a time
module ntm_vector_modular_multiplier
  import ntm_math_pkg::*;
#(
  parameter int DATA_SIZE    = DEFAULT_DATA_SIZE,
  parameter int CONTROL_SIZE = DEFAULT_CONTROL_SIZE
) (
  input  wire                     CLK,
  input  wire                     RST,

  // Vector framing
  input  wire                     start,
  output logic                    ready,

  // Element strobes
  input  wire                     data_a_in_enable,
  input  wire                     data_b_in_enable,
  output logic                    data_out_enable,

  // Data
  input  wire  [   DATA_SIZE-1:0] modulo_in,
  input  wire  [CONTROL_SIZE-1:0] size_in,
  input  wire  [   DATA_SIZE-1:0] data_a_in,
  input  wire  [   DATA_SIZE-1:0] data_b_in,
  output logic [   DATA_SIZE-1:0] data_out
);

  ////////////////////////////////////////////////////////////////////////////
  // Types and signals
  ////////////////////////////////////////////////////////////////////////////

  // Vector sequencer
  typedef enum logic [1:0] {
    starter_state = 2'd0,
    input_state   = 2'd1,
    ender_state   = 2'd2
  } vector_state_t;

  vector_state_t state;

  // Element position and index of the last element
  logic [CONTROL_SIZE-1:0] index_loop;
  logic [CONTROL_SIZE-1:0] last_index;

  // Operand already captured in an earlier cycle
  logic a_captured;
  logic b_captured;

  // Captured earlier or strobed now
  logic a_present;
  logic b_present;
  logic launch;

  // Scalar multiplier handshake
  logic start_scalar;
  logic ready_scalar;

  // Operands held for the scalar multiplier
  logic [DATA_SIZE-1:0] modulo_reg;
  logic [DATA_SIZE-1:0] data_a_reg;
  logic [DATA_SIZE-1:0] data_b_reg;
  logic [DATA_SIZE-1:0] data_out_scalar;

  ////////////////////////////////////////////////////////////////////////////
  // Operand collection
  ////////////////////////////////////////////////////////////////////////////

  assign a_present = a_captured | data_a_in_enable;
  assign b_present = b_captured | data_b_in_enable;

  // Second operand strobe starts the element on the next cycle
  assign launch = (state == input_state) && a_present && b_present;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= starter_state;
      ready           <= 1'b0;
      data_out_enable <= 1'b0;
      data_out        <= '0;
      start_scalar    <= 1'b0;
      index_loop      <= '0;
      a_captured      <= 1'b0;
      b_captured      <= 1'b0;
    end else begin
      // Pulses by default
      ready           <= 1'b0;
      data_out_enable <= 1'b0;
      start_scalar    <= 1'b0;
      case (state)
        starter_state: begin
          if (start) begin
            index_loop <= '0;
            a_captured <= 1'b0;
            b_captured <= 1'b0;
            state      <= input_state;
          end
        end
        input_state: begin
          if (launch) begin
            start_scalar <= 1'b1;
            a_captured   <= 1'b0;
            b_captured   <= 1'b0;
            state        <= ender_state;
          end else begin
            a_captured <= a_present;
            b_captured <= b_present;
          end
        end
        ender_state: begin
          // Strobes ignored while the element computes
          if (ready_scalar) begin
            data_out        <= data_out_scalar;
            data_out_enable <= 1'b1;
            if (index_loop == last_index) begin
              // Last element, close the vector
              ready <= 1'b1;
              state <= starter_state;
            end else begin
              index_loop <= index_loop + 1'b1;
              state      <= input_state;
            end
          end
        end
        default: begin
          state <= starter_state;
        end
      endcase
    end
  end

  // Modulus and length latched at vector start, operands on their strobes
  always_ff @(posedge CLK) begin
    if (state == starter_state && start) begin
      modulo_reg <= modulo_in;
      last_index <= size_in - 1'b1;
    end
    if (state == input_state && data_a_in_enable) begin
      data_a_reg <= data_a_in;
    end
    if (state == input_state && data_b_in_enable) begin
      data_b_reg <= data_b_in;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Scalar multiplier
  ////////////////////////////////////////////////////////////////////////////

  ntm_scalar_modular_multiplier #(
    .DATA_SIZE   (DATA_SIZE),
    .CONTROL_SIZE(CONTROL_SIZE)
  ) u_scalar_multiplier (
    .CLK      (CLK),
    .RST      (RST),
    .start    (start_scalar),
    .ready    (ready_scalar),
    .modulo_in(modulo_reg),
    .data_a_in(data_a_reg),
    .data_b_in(data_b_reg),
    .data_out (data_out_scalar)
  );

endmodule

`default_nettype wire

// File: sources.f
rtl/ntm_math_pkg.sv
rtl/ntm_scalar_modular_reducer.sv
rtl/ntm_scalar_modular_multiplier.sv
rtl/ntm_vector_modular_multiplier.sv
verif/tb_ntm_vector_modular_multiplier.sv

// File: verif/ntm_vector_modular_cases.txt
// Header line: modulus, length, strobe order (0 A then B, 1 B then A, 2 same cycle, 3 gap)
// Element line: A, B, expected A * B mod modulus; a zero modulus ends the file

// Small prime, single element
00FB 0001 0000
0012 0034 00B7

// Largest 16-bit modulus, eight elements, strobes together
FFFF 0008 0002
FFFF FFFF 0000
FFFE FFFE 0001
1234 0001 1234
8000 0002 0001
0100 0100 0001
ABCD 0000 0000
00FF 0101 0000
7FFF 0003 7FFE

// Modulus of one, B before A
0001 0002 0001
FFFF FFFF 0000
1234 5678 0000

// Operands above the modulus, gap between strobes
03E8 0003 0003
FFFF 0002 0046
07D1 07D3 0003
01F4 0003 01F4

// Odd modulus just above half range
8001 0002 0000
8000 8000 0001
FFFF 0002 7FFB

// Small modulus, B before A
000D 0004 0001
0005 0006 0004
000C 000C 0001
FFFF 0001 0002
0064 0064 0003

// All-ones operands against modulus FFFE
FFFE 0001 0003
FFFF FFFF 0001

// End of cases
0000 0000 0000

// File: verif/tb_ntm_vector_modular_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ntm_vector_modular_multiplier;

  ////////////////////////////////////////////////////////////////////////////
  // Parameters and signals
  ////////////////////////////////////////////////////////////////////////////

  localparam int DATA_SIZE    = 16;
  localparam int CONTROL_SIZE = 8;

  // Negedges from the second strobe to the first sight of data_out_enable
  localparam int ELEMENT_LATENCY = 2 * DATA_SIZE + 5;
  localparam int TIMEOUT_CYCLES  = 4 * ELEMENT_LATENCY;

  // Room for header and element lines of three words each
  localparam int CASE_WORDS = 256;

  // Idle cycles between the two strobes for order code 3
  localparam int GAP_CYCLES = 5;

  logic                    CLK;
  logic                    RST;
  logic                    start;
  logic                    ready;
  logic                    data_a_in_enable;
  logic                    data_b_in_enable;
  logic                    data_out_enable;
  logic [   DATA_SIZE-1:0] modulo_in;
  logic [CONTROL_SIZE-1:0] size_in;
  logic [   DATA_SIZE-1:0] data_a_in;
  logic [   DATA_SIZE-1:0] data_b_in;
  logic [   DATA_SIZE-1:0] data_out;

  logic [DATA_SIZE-1:0] case_words [0:CASE_WORDS-1];

  int checks;
  int value_errors;
  int timeouts;

  // Pulse totals seen by the monitor
  int out_pulses;
  int ready_pulses;

  ntm_vector_modular_multiplier #(
    .DATA_SIZE   (DATA_SIZE),
    .CONTROL_SIZE(CONTROL_SIZE)
  ) u_dut (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .ready           (ready),
    .data_a_in_enable(data_a_in_enable),
    .data_b_in_enable(data_b_in_enable),
    .data_out_enable (data_out_enable),
    .modulo_in       (modulo_in),
    .size_in         (size_in),
    .data_a_in       (data_a_in),
    .data_b_in       (data_b_in),
    .data_out        (data_out)
  );

  // 40 ns period
  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Monitor
  ////////////////////////////////////////////////////////////////////////////

  // One negedge per output pulse
  always @(negedge CLK) begin
    if (data_out_enable) begin
      out_pulses++;
    end
    if (ready) begin
      ready_pulses++;
      // Vector end shares its cycle with the last result
      assert (data_out_enable === 1'b1) else begin
        value_errors++;
        $display("ERR %0t: ready pulse without data_out_enable", $time);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input int case_no, input int index,
                             input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      value_errors++;
      $display("ERR %0t: case %0d element %0d %s expected %0h got %0h",
               $time, case_no, index, what, expected, actual);
    end
  endtask

  // Strobes one element pair in the given order and checks its result
  task automatic run_element(input int case_no, input int index, input int order,
                             input logic [DATA_SIZE-1:0] a, input logic [DATA_SIZE-1:0] b,
                             input logic [DATA_SIZE-1:0] expected, input bit last);
    int waited;
    // Short idle gap that differs per element
    repeat (index % 3) @(negedge CLK);
    data_a_in = a;
    data_b_in = b;
    case (order)
      0: begin
        data_a_in_enable = 1'b1;
        @(negedge CLK);
        data_a_in_enable = 1'b0;
        data_b_in_enable = 1'b1;
      end
      1: begin
        data_b_in_enable = 1'b1;
        @(negedge CLK);
        data_b_in_enable = 1'b0;
        data_a_in_enable = 1'b1;
      end
      2: begin
        data_a_in_enable = 1'b1;
        data_b_in_enable = 1'b1;
      end
      default: begin
        data_a_in_enable = 1'b1;
        @(negedge CLK);
        data_a_in_enable = 1'b0;
        repeat (GAP_CYCLES) @(negedge CLK);
        data_b_in_enable = 1'b1;
      end
    endcase
    // Second strobe is high now
    waited = 0;
    do begin
      @(negedge CLK);
      waited++;
      data_a_in_enable = 1'b0;
      data_b_in_enable = 1'b0;
      // Operands must have been captured on the strobe
      data_a_in = ~a;
      data_b_in = ~b;
    end while (data_out_enable !== 1'b1 && waited < TIMEOUT_CYCLES);
    if (data_out_enable !== 1'b1) begin
      timeouts++;
      $display("Timeout: element %0d of case %0d never completed", index, case_no);
    end else begin
      check_value("latency", case_no, index, ELEMENT_LATENCY, waited);
      check_value("product", case_no, index, expected, data_out);
      check_value("ready", case_no, index, last, ready);
    end
  endtask

  // Walks the case file until the terminating zero modulus
  task automatic walk_case_file();
    int ptr;
    int case_no;
    int length;
    int order;
    int index;
    int expected_outputs;
    ptr = 0;
    case_no = 0;
    expected_outputs = 0;
    while (timeouts == 0 && ptr + 2 < CASE_WORDS && case_words[ptr] != '0) begin
      length = int'(case_words[ptr + 1]);
      order  = int'(case_words[ptr + 2]);
      // Modulus and length held for the whole vector
      modulo_in = case_words[ptr];
      size_in   = CONTROL_SIZE'(length);
      ptr += 3;
      start = 1'b1;
      @(negedge CLK);
      start = 1'b0;
      for (index = 0; index < length && timeouts == 0; index++) begin
        run_element(case_no, index, order, case_words[ptr], case_words[ptr + 1],
                    case_words[ptr + 2], index == length - 1);
        ptr += 3;
      end
      expected_outputs += length;
      // Stray pulses would show up in the totals
      repeat (4) @(negedge CLK);
      if (timeouts == 0) begin
        check_value("data_out_enable total", case_no, length, expected_outputs, out_pulses);
        check_value("ready total", case_no, length, case_no + 1, ready_pulses);
      end
      case_no++;
    end
    assert (case_no > 0) else begin
      value_errors++;
      $display("No cases were read from the case file");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    RST              = 1'b1;
    start            = 1'b0;
    data_a_in_enable = 1'b0;
    data_b_in_enable = 1'b0;
    modulo_in        = '0;
    size_in          = '0;
    data_a_in        = '0;
    data_b_in        = '0;
    checks           = 0;
    value_errors     = 0;
    timeouts         = 0;
    out_pulses       = 0;
    ready_pulses     = 0;
    $readmemh("verif/ntm_vector_modular_cases.txt", case_words);
    // Reset for 2 cycles
    repeat (2) @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);
    check_value("ready after reset", 0, 0, 0, ready);
    check_value("data_out_enable after reset", 0, 0, 0, data_out_enable);
    check_value("data_out after reset", 0, 0, 0, data_out);
    walk_case_file();
    $display("Checks %0d, value errors %0d, timeouts %0d", checks, value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire
